//--- mips_pkg.sv
package mips_pkg;

    // Data and address width
    localparam int WORD_W = 32;
    // Register index width
    localparam int REG_ADDR_W = 5;

    // Primary opcodes handled by this core
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'd0,
        OP_J       = 6'd2,
        OP_BEQ     = 6'd4,
        OP_BNE     = 6'd5,
        OP_ADDIU   = 6'd9,
        OP_SLTI    = 6'd10,
        OP_SLTIU   = 6'd11,
        OP_ANDI    = 6'd12,
        OP_ORI     = 6'd13,
        OP_XORI    = 6'd14,
        OP_LUI     = 6'd15,
        OP_LW      = 6'd35,
        OP_SW      = 6'd43
    } opcode_t;

    // Function field of SPECIAL instructions
    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_JR   = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } funct_t;

    // Sequencer states
    typedef enum logic [1:0] {
        FETCH = 2'd0,
        EXEC  = 2'd1,
        MEM   = 2'd2,
        HALT  = 2'd3
    } state_t;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_t;

    // What the sequencer does with an instruction
    typedef enum logic [2:0] {
        CL_ALU, CL_LOAD, CL_STORE, CL_BRANCH_EQ,
        CL_BRANCH_NE, CL_JUMP, CL_JUMP_REG, CL_NOP
    } instr_class_t;

    // Decoded instruction, shared by control and datapath
    typedef struct packed {
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [4:0]            shamt;
        logic [REG_ADDR_W-1:0] dest;
        logic [WORD_W-1:0]     imm_ext;
        logic [25:0]           target;
        alu_op_t               alu_op;
        logic                  use_imm;
        instr_class_t          iclass;
    } decoded_t;

    // One bus request as seen by the memory
    typedef struct packed {
        logic [WORD_W-1:0] address;
        logic              read;
        logic              write;
        logic [WORD_W-1:0] writedata;
        logic [3:0]        byteenable;
    } mem_req_t;

endpackage

//--- mips_alu.sv
`timescale 1ns/10ps

module mips_alu (
    input  mips_pkg::decoded_t          dec,
    input  logic [mips_pkg::WORD_W-1:0] rs_value,
    input  logic [mips_pkg::WORD_W-1:0] rt_value,
    output logic [mips_pkg::WORD_W-1:0] result
);
    import mips_pkg::*;

    logic [WORD_W-1:0] op_a;
    logic [WORD_W-1:0] op_b;
    logic [WORD_W-1:0] diff;

    assign op_a = rs_value;
    // Immediate forms replace rt with the extended constant
    assign op_b = dec.use_imm ? dec.imm_ext : rt_value;
    assign diff = op_a - op_b;

    always_comb begin
        result = '0;
        case (dec.alu_op)
            // Also forms the LW/SW address
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = diff;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_XOR: result = op_a ^ op_b;
            ALU_SLT: begin
                result = {{(WORD_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            end
            ALU_SLTU: begin
                result = {{(WORD_W-1){1'b0}}, op_a < op_b};
            end
            // Shifts use rt and the shamt field only
            ALU_SLL: result = rt_value << dec.shamt;
            ALU_SRL: result = rt_value >> dec.shamt;
            ALU_SRA: result = $signed(rt_value) >>> dec.shamt;
            // Immediate into the upper half, low half cleared
            ALU_LUI: result = {dec.imm_ext[15:0], 16'b0};
            default: result = '0;
        endcase
    end

endmodule

//--- mips_decoder.sv
`timescale 1ns/10ps

module mips_decoder (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        ir_load,
    input  logic [mips_pkg::WORD_W-1:0] readdata,
    output mips_pkg::decoded_t          dec
);
    import mips_pkg::*;

    logic [WORD_W-1:0] ir;
    opcode_t           opcode;
    funct_t            funct;
    logic [15:0]       imm;
    logic              sign_ext;
    logic              rd_dest;

    // Instruction register, loaded when the fetch completes
    always_ff @(posedge clk) begin
        if (reset) begin
            ir <= '0;
        end else if (ir_load) begin
            ir <= readdata;
        end
    end

    assign opcode = opcode_t'(ir[31:26]);
    assign funct  = funct_t'(ir[5:0]);
    assign imm    = ir[15:0];

    always_comb begin
        dec        = '0;
        dec.rs     = ir[25:21];
        dec.rt     = ir[20:16];
        dec.shamt  = ir[10:6];
        dec.target = ir[25:0];
        dec.alu_op = ALU_ADD;
        dec.use_imm = 1'b1;
        dec.iclass = CL_NOP;
        sign_ext   = 1'b1;
        rd_dest    = 1'b0;

        case (opcode)
            OP_SPECIAL: begin
                // Register operands, result goes to rd
                dec.use_imm = 1'b0;
                rd_dest     = 1'b1;
                dec.iclass  = CL_ALU;
                case (funct)
                    FN_ADDU: dec.alu_op = ALU_ADD;
                    FN_SUBU: dec.alu_op = ALU_SUB;
                    FN_AND:  dec.alu_op = ALU_AND;
                    FN_OR:   dec.alu_op = ALU_OR;
                    FN_XOR:  dec.alu_op = ALU_XOR;
                    FN_SLT:  dec.alu_op = ALU_SLT;
                    FN_SLTU: dec.alu_op = ALU_SLTU;
                    FN_SLL:  dec.alu_op = ALU_SLL;
                    FN_SRL:  dec.alu_op = ALU_SRL;
                    FN_SRA:  dec.alu_op = ALU_SRA;
                    FN_JR:   dec.iclass = CL_JUMP_REG;
                    default: dec.iclass = CL_NOP;
                endcase
            end
            OP_ADDIU: dec.iclass = CL_ALU;
            OP_SLTI: begin
                dec.iclass = CL_ALU;
                dec.alu_op = ALU_SLT;
            end
            // SLTIU still sign-extends, then compares unsigned
            OP_SLTIU: begin
                dec.iclass = CL_ALU;
                dec.alu_op = ALU_SLTU;
            end
            OP_ANDI: begin
                dec.iclass = CL_ALU;
                dec.alu_op = ALU_AND;
                sign_ext   = 1'b0;
            end
            OP_ORI: begin
                dec.iclass = CL_ALU;
                dec.alu_op = ALU_OR;
                sign_ext   = 1'b0;
            end
            OP_XORI: begin
                dec.iclass = CL_ALU;
                dec.alu_op = ALU_XOR;
                sign_ext   = 1'b0;
            end
            OP_LUI: begin
                dec.iclass = CL_ALU;
                dec.alu_op = ALU_LUI;
            end
            OP_LW:   dec.iclass = CL_LOAD;
            OP_SW:   dec.iclass = CL_STORE;
            OP_BEQ:  dec.iclass = CL_BRANCH_EQ;
            OP_BNE:  dec.iclass = CL_BRANCH_NE;
            OP_J:    dec.iclass = CL_JUMP;
            default: dec.iclass = CL_NOP;
        endcase

        // I-type results land in rt
        dec.dest    = rd_dest ? ir[15:11] : ir[20:16];
        dec.imm_ext = sign_ext ? {{16{imm[15]}}, imm} : {16'b0, imm};
    end

endmodule

//--- mips_regfile.sv
`timescale 1ns/10ps

module mips_regfile (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [mips_pkg::REG_ADDR_W-1:0] rs,
    input  logic [mips_pkg::REG_ADDR_W-1:0] rt,
    input  logic [mips_pkg::REG_ADDR_W-1:0] waddr,
    input  logic                            wen,
    input  logic [mips_pkg::WORD_W-1:0]     wdata,
    output logic [mips_pkg::WORD_W-1:0]     rs_value,
    output logic [mips_pkg::WORD_W-1:0]     rt_value,
    output logic [mips_pkg::WORD_W-1:0]     v0
);
    import mips_pkg::*;

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    logic [WORD_W-1:0] regs [NUM_REGS];

    // All registers start at zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != '0)) begin
            // Register 0 is never written so it reads as zero
            regs[waddr] <= wdata;
        end
    end

    // Asynchronous read ports
    assign rs_value = regs[rs];
    assign rt_value = regs[rt];

    // Result register v0 is index 2
    assign v0 = regs[2];

endmodule

//--- mips_pc_unit.sv
`timescale 1ns/10ps

module mips_pc_unit #(
    parameter logic [mips_pkg::WORD_W-1:0] RESET_VECTOR = 32'hBFC0_0000
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        pc_step,
    input  mips_pkg::decoded_t          dec,
    input  logic [mips_pkg::WORD_W-1:0] rs_value,
    input  logic [mips_pkg::WORD_W-1:0] rt_value,
    output logic [mips_pkg::WORD_W-1:0] pc
);
    import mips_pkg::*;

    logic [WORD_W-1:0] pc_plus4;
    logic [WORD_W-1:0] branch_target;
    logic [WORD_W-1:0] jump_target;
    logic [WORD_W-1:0] pc_next;
    logic              operands_equal;
    logic              taken;

    assign pc_plus4      = pc + 32'd4;
    // Word offset relative to the following instruction
    assign branch_target = pc_plus4 + {dec.imm_ext[WORD_W-3:0], 2'b00};
    // Stays inside the current 256 MB segment
    assign jump_target   = {pc_plus4[31:28], dec.target, 2'b00};

    // Branch decision is made here, not in the ALU
    assign operands_equal = (rs_value == rt_value);
    assign taken = ((dec.iclass == CL_BRANCH_EQ) && operands_equal)
                || ((dec.iclass == CL_BRANCH_NE) && !operands_equal);

    always_comb begin
        pc_next = pc_plus4;
        if (taken) begin
            pc_next = branch_target;
        end else if (dec.iclass == CL_JUMP) begin
            pc_next = jump_target;
        end else if (dec.iclass == CL_JUMP_REG) begin
            pc_next = rs_value;
        end
    end

    // No delay slot so the target is taken directly
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_VECTOR;
        end else if (pc_step) begin
            pc <= pc_next;
        end
    end

endmodule

//--- mips_control.sv
`timescale 1ns/10ps

module mips_control (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        waitrequest,
    input  mips_pkg::decoded_t          dec,
    input  logic [mips_pkg::WORD_W-1:0] pc,
    input  logic [mips_pkg::WORD_W-1:0] alu_result,
    input  logic [mips_pkg::WORD_W-1:0] rt_value,
    output mips_pkg::mem_req_t          mem_req,
    output logic                        ir_load,
    output logic                        reg_write,
    output logic                        wb_from_mem,
    output logic                        pc_step,
    output logic                        active
);
    import mips_pkg::*;

    state_t state;
    state_t state_next;
    logic   is_load;
    logic   is_store;

    assign is_load  = (dec.iclass == CL_LOAD);
    assign is_store = (dec.iclass == CL_STORE);

    // CPU runs until it reaches HALT
    assign active = (state != HALT);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next  = state;
        ir_load     = 1'b0;
        reg_write   = 1'b0;
        wb_from_mem = 1'b0;
        pc_step     = 1'b0;

        // Idle bus by default, only full words are moved
        mem_req            = '0;
        mem_req.address    = pc;
        mem_req.byteenable = 4'hF;

        case (state)
            FETCH: begin
                // Address 0 is the halt vector and is never fetched
                if (pc == '0) begin
                    state_next = HALT;
                end else begin
                    mem_req.read = 1'b1;
                    // Capture the word in the cycle it is accepted
                    if (!waitrequest) begin
                        ir_load    = 1'b1;
                        state_next = EXEC;
                    end
                end
            end

            EXEC: begin
                if (is_load || is_store) begin
                    state_next = MEM;
                end else begin
                    // Branches, jumps and no-ops only advance the PC
                    reg_write  = (dec.iclass == CL_ALU);
                    pc_step    = 1'b1;
                    state_next = FETCH;
                end
            end

            MEM: begin
                // Effective address is rs plus offset from the ALU
                mem_req.address = alu_result;
                mem_req.read    = is_load;
                mem_req.write   = is_store;
                if (is_store) begin
                    mem_req.writedata = rt_value;
                end
                // Request held unchanged until the slave takes it
                if (!waitrequest) begin
                    reg_write   = is_load;
                    wb_from_mem = is_load;
                    pc_step     = 1'b1;
                    state_next  = FETCH;
                end
            end

            HALT: begin
                // Only reset leaves this state
                state_next = HALT;
            end

            default: begin
                state_next = HALT;
            end
        endcase
    end

endmodule

//--- mips_cpu_bus.sv
`timescale 1ns/10ps

module mips_cpu_bus #(
    parameter logic [mips_pkg::WORD_W-1:0] RESET_VECTOR = 32'hBFC0_0000
) (
    input  logic                        clk,
    input  logic                        reset,
    output logic                        active,
    output logic [mips_pkg::WORD_W-1:0] register_v0,

    // Avalon-style memory master
    output logic [mips_pkg::WORD_W-1:0] address,
    output logic                        write,
    output logic                        read,
    input  logic                        waitrequest,
    output logic [mips_pkg::WORD_W-1:0] writedata,
    output logic [3:0]                  byteenable,
    input  logic [mips_pkg::WORD_W-1:0] readdata
);
    import mips_pkg::*;

    decoded_t          dec;
    mem_req_t          mem_req;
    logic              ir_load;
    logic              reg_write;
    logic              wb_from_mem;
    logic              pc_step;
    logic [WORD_W-1:0] pc;
    logic [WORD_W-1:0] rs_value;
    logic [WORD_W-1:0] rt_value;
    logic [WORD_W-1:0] alu_result;
    logic [WORD_W-1:0] wb_data;

    // Loads write back the bus word, everything else the ALU result
    assign wb_data = wb_from_mem ? readdata : alu_result;

    mips_control i_control (
        .clk(clk), .reset(reset), .waitrequest(waitrequest),
        .dec(dec), .pc(pc), .alu_result(alu_result), .rt_value(rt_value),
        .mem_req(mem_req), .ir_load(ir_load), .reg_write(reg_write),
        .wb_from_mem(wb_from_mem), .pc_step(pc_step), .active(active)
    );

    mips_decoder i_decoder (
        .clk(clk), .reset(reset), .ir_load(ir_load), .readdata(readdata), .dec(dec)
    );

    mips_regfile i_regfile (
        .clk(clk), .reset(reset), .rs(dec.rs), .rt(dec.rt), .waddr(dec.dest),
        .wen(reg_write), .wdata(wb_data),
        .rs_value(rs_value), .rt_value(rt_value), .v0(register_v0)
    );

    mips_alu i_alu (
        .dec(dec), .rs_value(rs_value), .rt_value(rt_value), .result(alu_result)
    );

    mips_pc_unit #(.RESET_VECTOR(RESET_VECTOR)) i_pc_unit (
        .clk(clk), .reset(reset), .pc_step(pc_step), .dec(dec),
        .rs_value(rs_value), .rt_value(rt_value), .pc(pc)
    );

    // Flatten the request onto the bus pins
    assign address    = mem_req.address;
    assign read       = mem_req.read;
    assign write      = mem_req.write;
    assign writedata  = mem_req.writedata;
    assign byteenable = mem_req.byteenable;

endmodule

//--- mips_cpu_bus_asserts.sv
`timescale 1ns/10ps

module mips_cpu_bus_asserts #(
    parameter logic [mips_pkg::WORD_W-1:0] RESET_VECTOR = 32'hBFC0_0000
) (
    input logic                        clk,
    input logic                        reset,
    input logic                        active,
    input logic [mips_pkg::WORD_W-1:0] address,
    input logic                        read,
    input logic                        write,
    input logic [mips_pkg::WORD_W-1:0] writedata,
    input logic [3:0]                  byteenable,
    input logic                        waitrequest
);

    int unsigned fail_count = 0;

    // First cycle out of reset fetches from the reset vector
    first_fetch: assert property (@(posedge clk)
        $fell(reset) |-> read && !write && active && (address == RESET_VECTOR))
        else begin
            $error("first bus cycle after reset is not a read at the reset vector");
            fail_count++;
        end

    // Reset leaves the CPU running with no write pending
    reset_state: assert property (@(posedge clk) reset |=> active && !write)
        else begin
            $error("CPU not active or writing right after reset");
            fail_count++;
        end

    one_direction: assert property (@(posedge clk) disable iff (reset)
        !(read && write))
        else begin
            $error("read and write high in the same cycle");
            fail_count++;
        end

    // Only whole words travel on the bus
    full_word: assert property (@(posedge clk) disable iff (reset)
        (read || write) |-> (byteenable == 4'hF))
        else begin
            $error("byteenable not all ones during a bus access");
            fail_count++;
        end

    // Stalled request stays put until the slave takes it
    hold_on_wait: assert property (@(posedge clk) disable iff (reset)
        (waitrequest && (read || write)) |=>
            $stable(address) && $stable(read) && $stable(write) && $stable(writedata))
        else begin
            $error("bus request changed while waitrequest was high");
            fail_count++;
        end

    halt_quiet: assert property (@(posedge clk) disable iff (reset)
        !active |-> !read && !write)
        else begin
            $error("bus access issued after halt");
            fail_count++;
        end

    // Only reset brings the CPU back from halt
    halt_sticky: assert property (@(posedge clk) disable iff (reset)
        !active |=> !active)
        else begin
            $error("active rose again without reset");
            fail_count++;
        end

endmodule

bind mips_cpu_bus mips_cpu_bus_asserts #(
    .RESET_VECTOR(RESET_VECTOR)
) i_asserts (
    .clk(clk),
    .reset(reset),
    .active(active),
    .address(address),
    .read(read),
    .write(write),
    .writedata(writedata),
    .byteenable(byteenable),
    .waitrequest(waitrequest)
);

//--- tb_mips_cpu_bus.sv
`timescale 1ns/10ps

module tb_mips_cpu_bus;

    localparam logic [31:0] RESET_VECTOR       = 32'hBFC0_0000;
    localparam logic [31:0] DATA_BASE          = 32'h0000_1000;
    localparam int          MEM_WORDS          = 256;
    localparam int          CLK_PERIOD         = 8;
    localparam int          RESET_CYCLES       = 10;
    localparam int          NUM_PROGRAMS       = 3;
    localparam int          CYCLES_PER_PROGRAM = 4000;
    localparam int unsigned SEED               = 32'h0546_e25d;

    // MIPS I primary opcodes
    localparam int OP_J     = 2;
    localparam int OP_BEQ   = 4;
    localparam int OP_BNE   = 5;
    localparam int OP_ADDIU = 9;
    localparam int OP_ANDI  = 12;
    localparam int OP_ORI   = 13;
    localparam int OP_XORI  = 14;
    localparam int OP_LUI   = 15;
    localparam int OP_LW    = 35;
    localparam int OP_SW    = 43;
    // SPECIAL function codes
    localparam int FN_SLL  = 0;
    localparam int FN_SRL  = 2;
    localparam int FN_SRA  = 3;
    localparam int FN_JR   = 8;
    localparam int FN_ADDU = 33;
    localparam int FN_SUBU = 35;
    localparam int FN_XOR  = 38;
    localparam int FN_SLT  = 42;
    localparam int FN_SLTU = 43;

    logic        clk;
    logic        reset = 1'b1;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic        write;
    logic        read;
    logic        waitrequest = 1'b0;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic [31:0] readdata = '0;

    // Program region at the reset vector and data region at DATA_BASE
    logic [31:0] rom [MEM_WORDS];
    logic [31:0] ram [MEM_WORDS];
    logic [7:0]  next_slot = '0;
    logic        in_req = 1'b0;
    int          wait_left = 0;
    int          value_errors = 0;
    int          bus_errors = 0;

    mips_cpu_bus #(.RESET_VECTOR(RESET_VECTOR)) i_mips_cpu_bus (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] enc_r(input int rs, input int rt, input int rd,
                                          input int sh, input int fn);
        logic [31:0] w;
        w = '0;
        w[25:21] = rs[4:0];
        w[20:16] = rt[4:0];
        w[15:11] = rd[4:0];
        w[10:6]  = sh[4:0];
        w[5:0]   = fn[5:0];
        return w;
    endfunction

    function automatic logic [31:0] enc_i(input int op, input int rs, input int rt,
                                          input logic [15:0] imm);
        return {op[5:0], rs[4:0], rt[4:0], imm};
    endfunction

    // Jump field is the word index inside the 256 MB segment
    function automatic logic [31:0] enc_j(input int op, input logic [31:0] dest);
        return {op[5:0], dest[27:2]};
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return ~{addr[7:0], addr[31:8]} ^ addr;
    endfunction

    function automatic logic [31:0] load_word(input logic [31:0] addr);
        logic [31:0] rom_off;
        logic [31:0] ram_off;
        rom_off = addr - RESET_VECTOR;
        ram_off = addr - DATA_BASE;
        if (rom_off < MEM_WORDS * 4) begin
            return rom[rom_off[9:2]];
        end else if (ram_off < MEM_WORDS * 4) begin
            return ram[ram_off[9:2]];
        end
        return fill_word(addr);
    endfunction

    task automatic store_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] be);
        logic [31:0] off;
        logic [31:0] mask;
        off  = addr - DATA_BASE;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        if (off < MEM_WORDS * 4) begin
            ram[off[9:2]] = (ram[off[9:2]] & ~mask) | (data & mask);
        end else begin
            $display("Write outside the data region at address %h", addr);
            bus_errors++;
        end
    endtask

    // Refill both regions and restart program placement
    task automatic clear_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            rom[i[7:0]] = fill_word(RESET_VECTOR + {i[29:0], 2'b00});
            ram[i[7:0]] = fill_word(DATA_BASE + {i[29:0], 2'b00});
        end
        next_slot = '0;
    endtask

    task automatic put_instr(input logic [31:0] w);
        rom[next_slot] = w;
        next_slot++;
    endtask

    // Slave side picks 0 to 2 wait cycles per new request
    always @(negedge clk) begin
        if ((read || write) && !in_req) begin
            in_req    = 1'b1;
            wait_left = $urandom % 3;
        end
        if (in_req && (wait_left != 0)) begin
            wait_left   = wait_left - 1;
            waitrequest <= 1'b1;
        end else begin
            // Accepted at the coming rising edge
            if (in_req && write) begin
                store_word(address, writedata, byteenable);
            end
            in_req      = 1'b0;
            waitrequest <= 1'b0;
        end
        readdata <= read ? load_word(address) : '0;
    end

    task automatic run_program(input string name, input logic [31:0] expected);
        @(negedge clk);
        reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        // Halt shows as active dropping
        do begin
            @(negedge clk);
        end while (active);
        assert (register_v0 === expected)
        else begin
            $display("ERROR %s: expected %h, actual %h", name, expected, register_v0);
            value_errors++;
        end
    endtask

    initial begin
        #(NUM_PROGRAMS * CYCLES_PER_PROGRAM * CLK_PERIOD);
        $display("Timeout: CPU did not halt within %0d cycles per program",
                 CYCLES_PER_PROGRAM);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        logic [15:0] ia;
        logic [15:0] ib;
        logic [15:0] ic;
        logic [15:0] id;
        logic [15:0] ie;
        logic [31:0] r [32];
        logic [31:0] value;
        logic [31:0] word;
        void'($urandom(SEED));
        ia = 16'($urandom);
        ib = 16'($urandom);
        ic = 16'($urandom);
        id = 16'($urandom);
        // Negative upper half so SRA shifts in ones
        ie = 16'($urandom) | 16'h8000;

        // ALU program with a register model kept alongside
        clear_memory();
        put_instr(enc_i(OP_ADDIU, 0, 8, ia));
        r[8] = {{16{ia[15]}}, ia};
        put_instr(enc_i(OP_ORI, 0, 9, ib));
        r[9] = {16'h0, ib};
        put_instr(enc_i(OP_ANDI, 8, 10, ic));
        r[10] = r[8] & {16'h0, ic};
        put_instr(enc_i(OP_XORI, 9, 11, id));
        r[11] = r[9] ^ {16'h0, id};
        put_instr(enc_i(OP_LUI, 0, 12, ie));
        r[12] = {ie, 16'h0};
        put_instr(enc_r(10, 12, 13, 0, FN_ADDU));
        r[13] = r[10] + r[12];
        put_instr(enc_r(13, 11, 14, 0, FN_SUBU));
        r[14] = r[13] - r[11];
        put_instr(enc_r(14, 8, 15, 0, FN_SLT));
        r[15] = ($signed(r[14]) < $signed(r[8])) ? 32'd1 : 32'd0;
        put_instr(enc_r(14, 9, 16, 0, FN_SLTU));
        r[16] = (r[14] < r[9]) ? 32'd1 : 32'd0;
        put_instr(enc_r(0, 14, 17, 3, FN_SLL));
        r[17] = r[14] << 3;
        put_instr(enc_r(0, 14, 18, 5, FN_SRL));
        r[18] = r[14] >> 5;
        put_instr(enc_r(0, 12, 19, 7, FN_SRA));
        r[19] = $signed(r[12]) >>> 7;
        put_instr(enc_r(17, 18, 2, 0, FN_ADDU));
        put_instr(enc_r(2, 19, 2, 0, FN_XOR));
        put_instr(enc_r(2, 15, 2, 0, FN_SUBU));
        put_instr(enc_r(2, 16, 2, 0, FN_ADDU));
        put_instr(enc_r(0, 0, 0, 0, FN_JR));
        run_program("alu", ((r[17] + r[18]) ^ r[19]) - r[15] + r[16]);

        // Store a derived word and reload it through a negative offset
        clear_memory();
        value = $urandom;
        word  = value ^ 32'h0000_5A5A;
        put_instr(enc_i(OP_ADDIU, 0, 8, DATA_BASE[15:0]));
        put_instr(enc_i(OP_LUI, 0, 9, value[31:16]));
        put_instr(enc_i(OP_ORI, 9, 9, value[15:0]));
        put_instr(enc_i(OP_XORI, 9, 10, 16'h5A5A));
        put_instr(enc_i(OP_SW, 8, 10, 16'd8));
        put_instr(enc_i(OP_ADDIU, 8, 11, 16'd16));
        put_instr(enc_i(OP_LW, 11, 2, 16'hFFF8));
        put_instr(enc_r(0, 0, 0, 0, FN_JR));
        run_program("memory", word);
        assert (ram[8'd2] === word)
        else begin
            $display("ERROR memory_word: expected %h, actual %h", word, ram[8'd2]);
            value_errors++;
        end

        // Skipped adds use large steps so any leak shows in v0
        clear_memory();
        put_instr(enc_i(OP_ADDIU, 0, 2, 16'd1));
        put_instr(enc_i(OP_ADDIU, 0, 8, 16'd5));
        put_instr(enc_i(OP_ADDIU, 0, 9, 16'd5));
        put_instr(enc_i(OP_BEQ, 8, 9, 16'd1));
        put_instr(enc_i(OP_ADDIU, 2, 2, 16'd100));
        put_instr(enc_i(OP_BNE, 8, 9, 16'd1));
        put_instr(enc_i(OP_ADDIU, 2, 2, 16'd2));
        put_instr(enc_i(OP_BNE, 8, 0, 16'd1));
        put_instr(enc_i(OP_ADDIU, 2, 2, 16'd200));
        put_instr(enc_i(OP_BEQ, 8, 0, 16'd1));
        put_instr(enc_i(OP_ADDIU, 2, 2, 16'd4));
        put_instr(enc_j(OP_J, RESET_VECTOR + 32'd52));
        put_instr(enc_i(OP_ADDIU, 2, 2, 16'd400));
        put_instr(enc_i(OP_ADDIU, 2, 2, 16'd8));
        put_instr(enc_r(0, 0, 0, 0, FN_JR));
        run_program("control", 32'd1 + 32'd2 + 32'd4 + 32'd8);

        $display("Errors: %0d value, %0d bus, %0d assertion", value_errors, bus_errors,
                 i_mips_cpu_bus.i_asserts.fail_count);
        if ((value_errors == 0) && (bus_errors == 0)
                && (i_mips_cpu_bus.i_asserts.fail_count == 0)) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- mips_cpu_bus.f
mips_pkg.sv
mips_alu.sv
mips_decoder.sv
mips_regfile.sv
mips_pc_unit.sv
mips_control.sv
mips_cpu_bus.sv
mips_cpu_bus_asserts.sv
tb_mips_cpu_bus.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator and run; success only when the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_mips_cpu_bus \
    -f mips_cpu_bus.f -o sim_tb &&
./obj_dir/sim_tb +verilator+error+limit+1000 | tee /dev/stderr |
    grep -x "Result: PASSED" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
